//--- design/md_filter_macros.svh
//////////////////////////////////////////////////
// Sizing, pipeline depth and cutoff of the filter bank
// Lane count and FIFO depth must be powers of two, lanes at least 2
// MD_FILTER_STAGES must match the two-stage filter pipeline
//////////////////////////////////////////////////
`ifndef MD_FILTER_MACROS_SVH
`define MD_FILTER_MACROS_SVH

// Signed fixed-point coordinate
`define MD_COORD_W 16

// Difference of two coordinates needs one more bit
`define MD_DIFF_W (`MD_COORD_W + 1)

// Three squares summed
`define MD_R2_W (2 * `MD_DIFF_W + 2)

`define MD_ID_W 20

`define MD_NUM_LANES 4

`define MD_FIFO_DEPTH 16

`define MD_FILTER_STAGES 2

// Cutoff radius 2048 coordinate units, squared
`define MD_CUTOFF_R2 (`MD_R2_W'(36'd4194304))

`endif

//--- design/particle_pkg.sv
//////////////////////////////////////////////////
// Particle level types
// Displacements are reference minus neighbor
//////////////////////////////////////////////////
`include "md_filter_macros.svh"

package particle_pkg;

	typedef logic signed [`MD_COORD_W-1:0] coord_t;

	typedef logic signed [`MD_DIFF_W-1:0] diff_t;

	typedef logic [`MD_R2_W-1:0] r2_t;

	typedef logic [`MD_ID_W-1:0] particle_id_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} position_t;

	// Lane input
	typedef struct packed {
		particle_id_t ref_id;
		particle_id_t neighbor_id;
		position_t    ref_pos;
		position_t    neighbor_pos;
	} candidate_pair_t;

	// FIFO entry and bank output
	typedef struct packed {
		particle_id_t ref_id;
		particle_id_t neighbor_id;
		diff_t        dx;
		diff_t        dy;
		diff_t        dz;
		r2_t          r2;
	} filtered_pair_t;

endpackage

//--- design/filter_bank_pkg.sv
//////////////////////////////////////////////////
// Bank level types for lanes and buffering
//////////////////////////////////////////////////
`include "md_filter_macros.svh"

package filter_bank_pkg;

	// One bit per lane
	typedef logic [`MD_NUM_LANES-1:0] lane_mask_t;

	typedef logic [$clog2(`MD_NUM_LANES)-1:0] lane_idx_t;

	// Occupancy from empty up to full
	typedef logic [$clog2(`MD_FIFO_DEPTH + 1)-1:0] fifo_count_t;

endpackage

//--- design/pair_distance_filter.sv
//////////////////////////////////////////////////
// Two-stage r2 filter, never stalls
// Kept pairs appear on wr_valid two edges after in_valid
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "md_filter_macros.svh"

module pair_distance_filter (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         in_valid,
	input  particle_pkg::candidate_pair_t in_pair,
	output logic                         wr_valid,
	output particle_pkg::filtered_pair_t  wr_pair
);

	logic s1_valid;
	particle_pkg::particle_id_t s1_ref_id;
	particle_pkg::particle_id_t s1_neighbor_id;
	particle_pkg::diff_t s1_dx;
	particle_pkg::diff_t s1_dy;
	particle_pkg::diff_t s1_dz;
	logic signed [2*`MD_DIFF_W-1:0] sq_x;
	logic signed [2*`MD_DIFF_W-1:0] sq_y;
	logic signed [2*`MD_DIFF_W-1:0] sq_z;
	particle_pkg::r2_t r2_sum;

	//////////////////////////////////////////////////
	// Stage 1, displacement
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			s1_ref_id      <= in_pair.ref_id;
			s1_neighbor_id <= in_pair.neighbor_id;
			s1_dx <= particle_pkg::diff_t'(in_pair.ref_pos.x)
				- particle_pkg::diff_t'(in_pair.neighbor_pos.x);
			s1_dy <= particle_pkg::diff_t'(in_pair.ref_pos.y)
				- particle_pkg::diff_t'(in_pair.neighbor_pos.y);
			s1_dz <= particle_pkg::diff_t'(in_pair.ref_pos.z)
				- particle_pkg::diff_t'(in_pair.neighbor_pos.z);
		end
	end

	//////////////////////////////////////////////////
	// Stage 2, sum of squares and cutoff
	//////////////////////////////////////////////////
	assign sq_x = s1_dx * s1_dx;
	assign sq_y = s1_dy * s1_dy;
	assign sq_z = s1_dz * s1_dz;

	// Squares are never negative
	assign r2_sum = particle_pkg::r2_t'(sq_x) + particle_pkg::r2_t'(sq_y)
		+ particle_pkg::r2_t'(sq_z);

	always_ff @(posedge clk)
	begin
		if (s1_valid)
		begin
			wr_pair.ref_id      <= s1_ref_id;
			wr_pair.neighbor_id <= s1_neighbor_id;
			wr_pair.dx          <= s1_dx;
			wr_pair.dy          <= s1_dy;
			wr_pair.dz          <= s1_dz;
			wr_pair.r2          <= r2_sum;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			wr_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= in_valid;
			// Strictly below the cutoff
			wr_valid <= s1_valid && (r2_sum < `MD_CUTOFF_R2);
		end
	end

endmodule

//--- design/pair_fifo.sv
//////////////////////////////////////////////////
// Per-lane buffer of kept pairs
// in_ready reserves room for pairs still in the filter
// Writes are never refused, pop only when not_empty
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "md_filter_macros.svh"

module pair_fifo (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        in_valid,
	input  logic                        wr_valid,
	input  particle_pkg::filtered_pair_t wr_pair,
	input  logic                        pop,
	output logic                        in_ready,
	output logic                        not_empty,
	output particle_pkg::filtered_pair_t head_pair
);

	localparam int ADDR_W = $clog2(`MD_FIFO_DEPTH);
	localparam int RES_W = $clog2(`MD_FIFO_DEPTH + `MD_FILTER_STAGES + 1);

	particle_pkg::filtered_pair_t mem [`MD_FIFO_DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	filter_bank_pkg::fifo_count_t count;
	logic [`MD_FILTER_STAGES-1:0] accept_pipe;
	logic [RES_W-1:0] reserved;
	logic accept;

	assign accept = in_valid && in_ready;

	// Stored entries plus accepted pairs not yet through the filter
	assign reserved = RES_W'(count) + RES_W'($countones(accept_pipe));
	assign in_ready = reserved <= RES_W'(`MD_FIFO_DEPTH - 1);

	assign not_empty = count != '0;
	assign head_pair = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (wr_valid)
			mem[wr_ptr] <= wr_pair;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			accept_pipe <= '0;
		end
		else
		begin
			accept_pipe <= {accept_pipe[`MD_FILTER_STAGES-2:0], accept};
			if (wr_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- design/round_robin_arbiter.sv
//////////////////////////////////////////////////
// Rotating-priority grant, combinational in the cycle
// Lane 0 has top priority after reset
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "md_filter_macros.svh"

module round_robin_arbiter (
	input  logic                        clk,
	input  logic                        rst_n,
	input  filter_bank_pkg::lane_mask_t request,
	input  logic                        advance,
	output filter_bank_pkg::lane_mask_t grant
);

	filter_bank_pkg::lane_idx_t ptr;
	filter_bank_pkg::lane_idx_t grant_idx;
	logic found;

	// First requester at or after the pointer
	always_comb
	begin
		int idx;
		grant     = '0;
		grant_idx = ptr;
		found     = 1'b0;
		for (int off = 0; off < `MD_NUM_LANES; off++)
		begin
			idx = (int'(ptr) + off) % `MD_NUM_LANES;
			if (!found && request[idx])
			begin
				found     = 1'b1;
				grant_idx = filter_bank_pkg::lane_idx_t'(idx);
			end
		end
		if (advance && found)
			grant[grant_idx] = 1'b1;
	end

	// Lane after the winner goes first next time
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ptr <= '0;
		else if (|grant)
		begin
			if (int'(grant_idx) == `MD_NUM_LANES - 1)
				ptr <= '0;
			else
				ptr <= grant_idx + 1'b1;
		end
	end

endmodule

//--- design/filter_bank.sv
//////////////////////////////////////////////////
// Multi-lane pair filter bank with one output port
// Output register holds its pair until out_ready
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "md_filter_macros.svh"

module filter_bank (
	input  logic                          clk,
	input  logic                          rst_n,
	input  filter_bank_pkg::lane_mask_t   in_valid,
	input  particle_pkg::candidate_pair_t in_pair [`MD_NUM_LANES],
	output filter_bank_pkg::lane_mask_t   in_ready,
	output logic                          out_valid,
	output particle_pkg::filtered_pair_t  out_pair,
	input  logic                          out_ready
);

	logic wr_valid [`MD_NUM_LANES];
	particle_pkg::filtered_pair_t wr_pair [`MD_NUM_LANES];
	particle_pkg::filtered_pair_t head_pair [`MD_NUM_LANES];
	filter_bank_pkg::lane_mask_t not_empty;
	filter_bank_pkg::lane_mask_t grant;
	filter_bank_pkg::lane_idx_t sel_idx;
	particle_pkg::filtered_pair_t sel_pair;
	logic advance;

	//////////////////////////////////////////////////
	// Lanes
	//////////////////////////////////////////////////
	for (genvar i = 0; i < `MD_NUM_LANES; i++)
	begin : g_lane
		pair_distance_filter u_filter (
			.clk      (clk),
			.rst_n    (rst_n),
			.in_valid (in_valid[i] && in_ready[i]),
			.in_pair  (in_pair[i]),
			.wr_valid (wr_valid[i]),
			.wr_pair  (wr_pair[i])
		);

		pair_fifo u_fifo (
			.clk       (clk),
			.rst_n     (rst_n),
			.in_valid  (in_valid[i]),
			.wr_valid  (wr_valid[i]),
			.wr_pair   (wr_pair[i]),
			.pop       (grant[i]),
			.in_ready  (in_ready[i]),
			.not_empty (not_empty[i]),
			.head_pair (head_pair[i])
		);
	end

	//////////////////////////////////////////////////
	// Arbitration and output register
	//////////////////////////////////////////////////
	// Output slot free or emptied on this edge
	assign advance = !out_valid || out_ready;

	round_robin_arbiter u_arbiter (
		.clk     (clk),
		.rst_n   (rst_n),
		.request (not_empty),
		.advance (advance),
		.grant   (grant)
	);

	always_comb
	begin
		sel_idx = '0;
		for (int i = 0; i < `MD_NUM_LANES; i++)
		begin
			if (grant[i])
				sel_idx = filter_bank_pkg::lane_idx_t'(i);
		end
	end

	assign sel_pair = head_pair[sel_idx];

	always_ff @(posedge clk)
	begin
		if (|grant)
			out_pair <= sel_pair;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (advance)
			out_valid <= |grant;
	end

endmodule

//--- verification/filter_bank_tb.sv
//////////////////////////////////////////////////
// Self-checking testbench for the filter bank
// Lane number rides in the top ref_id bits
// Expected pairs come from an integer model of the r2 rule
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "md_filter_macros.svh"

module filter_bank_tb;

	localparam int N = `MD_NUM_LANES;
	localparam int LANE_BITS = $clog2(`MD_NUM_LANES);
	localparam int CHECK_W = $bits(particle_pkg::filtered_pair_t);
	localparam int RANDOM_PAIRS = 40;
	localparam int FILL_PAIRS = 20;
	localparam int ROTATE_PAIRS = 4;
	localparam int READY_PAIRS = 40;
	localparam int TOTAL_PAIRS = N * (RANDOM_PAIRS + FILL_PAIRS + ROTATE_PAIRS + READY_PAIRS);
	localparam int MAX_CYCLES = TOTAL_PAIRS * 20 + 2000;
	localparam int DRAIN_CYCLES = N * `MD_FIFO_DEPTH * 16;
	localparam logic [31:0] SEED = 32'he971;

	logic clk;
	logic rst_n;
	filter_bank_pkg::lane_mask_t in_valid;
	particle_pkg::candidate_pair_t in_pair [N];
	filter_bank_pkg::lane_mask_t in_ready;
	logic out_valid;
	particle_pkg::filtered_pair_t out_pair;
	logic out_ready;

	logic [31:0] data_rng;
	logic [31:0] ready_rng;
	logic ready_random;
	logic dense;
	logic force_pass;
	int remaining [N];
	logic taken [N];
	int seq [N];
	particle_pkg::filtered_pair_t exp_q [N][$];
	int out_lanes [$];
	logic record_lanes;
	logic hold_pending;
	particle_pkg::filtered_pair_t held_pair;
	int value_errors;
	int other_errors;

	filter_bank dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_pair   (in_pair),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_pair  (out_pair),
		.out_ready (out_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		repeat (MAX_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////
	// Helpers and reference model
	//////////////////////////////////////////////////
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		data_rng = xorshift(data_rng);
		return data_rng;
	endfunction

	// Displacement is reference minus neighbor and r2 must stay below the cutoff
	function automatic logic expected_pair(input particle_pkg::candidate_pair_t p,
		output particle_pkg::filtered_pair_t e);
		longint dx;
		longint dy;
		longint dz;
		longint r2;
		dx = longint'(p.ref_pos.x) - longint'(p.neighbor_pos.x);
		dy = longint'(p.ref_pos.y) - longint'(p.neighbor_pos.y);
		dz = longint'(p.ref_pos.z) - longint'(p.neighbor_pos.z);
		r2 = dx * dx + dy * dy + dz * dz;
		e.ref_id      = p.ref_id;
		e.neighbor_id = p.neighbor_id;
		e.dx          = particle_pkg::diff_t'(dx);
		e.dy          = particle_pkg::diff_t'(dy);
		e.dz          = particle_pkg::diff_t'(dz);
		e.r2          = particle_pkg::r2_t'(r2);
		return r2 < longint'(`MD_CUTOFF_R2);
	endfunction

	function automatic particle_pkg::candidate_pair_t build_pair(input int lane);
		particle_pkg::candidate_pair_t p;
		logic [31:0] r;
		int span;
		int ox;
		int oy;
		int oz;
		span = force_pass ? 1000 : 2400;
		p.ref_id = particle_pkg::particle_id_t'(seq[lane]);
		p.ref_id[`MD_ID_W-1 -: LANE_BITS] = LANE_BITS'(lane);
		seq[lane]++;
		p.neighbor_id = particle_pkg::particle_id_t'(next_random());
		p.ref_pos.x = particle_pkg::coord_t'(int'(next_random() % 32001) - 16000);
		p.ref_pos.y = particle_pkg::coord_t'(int'(next_random() % 32001) - 16000);
		p.ref_pos.z = particle_pkg::coord_t'(int'(next_random() % 32001) - 16000);
		ox = int'(next_random() % (2 * span + 1)) - span;
		oy = int'(next_random() % (2 * span + 1)) - span;
		oz = int'(next_random() % (2 * span + 1)) - span;
		r = next_random();
		// Pairs on or just inside the cutoff sphere
		if (!force_pass && r[2:0] == 3'd0)
		begin
			ox = r[3] ? 2048 : 2047;
			if (r[4])
				ox = -ox;
			oy = 0;
			oz = 0;
		end
		p.neighbor_pos.x = particle_pkg::coord_t'(int'(p.ref_pos.x) - ox);
		p.neighbor_pos.y = particle_pkg::coord_t'(int'(p.ref_pos.y) - oy);
		p.neighbor_pos.z = particle_pkg::coord_t'(int'(p.ref_pos.z) - oz);
		return p;
	endfunction

	task automatic check_value(input string what, input logic [CHECK_W-1:0] got,
		input logic [CHECK_W-1:0] exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic int pairs_in_driver();
		int total;
		total = 0;
		for (int l = 0; l < N; l++)
			total += remaining[l] + ((in_valid[l] && !taken[l]) ? 1 : 0);
		return total;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////
	// Stops when all pairs are taken or after max_cycles unless that is 0
	task automatic run_traffic(input int max_cycles);
		int cycles;
		particle_pkg::filtered_pair_t e;
		cycles = 0;
		while (pairs_in_driver() != 0 && (max_cycles == 0 || cycles < max_cycles))
		begin
			@(posedge clk);
			#1;
			for (int l = 0; l < N; l++)
			begin
				if (taken[l])
				begin
					in_valid[l] = 1'b0;
					taken[l] = 1'b0;
				end
				if (!in_valid[l] && remaining[l] > 0 && (dense || next_random() % 4 != 0))
				begin
					in_pair[l] = build_pair(l);
					in_valid[l] = 1'b1;
					remaining[l]--;
				end
			end
			@(negedge clk);
			for (int l = 0; l < N; l++)
			begin
				if (in_valid[l] && in_ready[l])
				begin
					taken[l] = 1'b1;
					if (expected_pair(in_pair[l], e))
						exp_q[l].push_back(e);
				end
			end
			cycles++;
		end
		@(posedge clk);
		#1;
		for (int l = 0; l < N; l++)
		begin
			if (taken[l])
			begin
				in_valid[l] = 1'b0;
				taken[l] = 1'b0;
			end
		end
	endtask

	// Waits for every expected pair or gives up after DRAIN_CYCLES
	task automatic drain_outputs();
		int pending;
		int cycles;
		pending = 1;
		cycles = 0;
		while (pending != 0 && cycles < DRAIN_CYCLES)
		begin
			@(posedge clk);
			cycles++;
			pending = 0;
			for (int l = 0; l < N; l++)
				pending += exp_q[l].size();
		end
		#1;
	endtask

	initial
	begin
		forever
		begin
			@(posedge clk);
			#1;
			if (ready_random)
			begin
				ready_rng = xorshift(ready_rng);
				out_ready = ready_rng[3];
			end
		end
	end

	//////////////////////////////////////////////////
	// Output scoreboard
	//////////////////////////////////////////////////
	always @(negedge clk)
	begin : compare_outputs
		particle_pkg::filtered_pair_t e;
		int lane;
		if (hold_pending)
			check_value("out_pair while stalled", out_pair, held_pair);
		hold_pending = out_valid && !out_ready;
		held_pair = out_pair;
		if (out_valid && out_ready)
		begin
			lane = int'(out_pair.ref_id[`MD_ID_W-1 -: LANE_BITS]);
			if (record_lanes)
				out_lanes.push_back(lane);
			if (exp_q[lane].size() == 0)
			begin
				other_errors++;
				$display("unexpected pair at %0t: lane %0d had no passing pair pending",
					$time, lane);
			end
			else
			begin
				e = exp_q[lane].pop_front();
				check_value("ref_id", out_pair.ref_id, e.ref_id);
				check_value("neighbor_id", out_pair.neighbor_id, e.neighbor_id);
				check_value("dx", out_pair.dx, e.dx);
				check_value("dy", out_pair.dy, e.dy);
				check_value("dz", out_pair.dz, e.dz);
				check_value("r2", out_pair.r2, e.r2);
			end
		end
	end

	initial
	begin : main_sequence
		rst_n = 1'b0;
		in_valid = '0;
		out_ready = 1'b0;
		data_rng = SEED;
		// Second stream from the same seed
		ready_rng = {SEED[15:0], SEED[31:16]};
		ready_random = 1'b0;
		dense = 1'b0;
		force_pass = 1'b0;
		record_lanes = 1'b0;
		hold_pending = 1'b0;
		value_errors = 0;
		other_errors = 0;
		for (int l = 0; l < N; l++)
		begin
			in_pair[l] = '0;
			remaining[l] = 0;
			taken[l] = 1'b0;
			seq[l] = 0;
		end
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("out_valid after reset", out_valid, 1'b0);
		check_value("in_ready after reset", in_ready, {N{1'b1}});

		// Random traffic with the output always ready
		@(posedge clk);
		#1;
		out_ready = 1'b1;
		foreach (remaining[l]) remaining[l] = RANDOM_PAIRS;
		run_traffic(0);
		drain_outputs();

		// Stalled output fills every lane
		out_ready = 1'b0;
		force_pass = 1'b1;
		dense = 1'b1;
		foreach (remaining[l]) remaining[l] = FILL_PAIRS;
		run_traffic(FILL_PAIRS * 3);
		@(negedge clk);
		check_value("in_ready with output stalled", in_ready, '0);
		@(posedge clk);
		#1;
		out_ready = 1'b1;
		run_traffic(0);
		drain_outputs();

		// Prefill all lanes and then watch the grant rotation
		out_ready = 1'b0;
		foreach (remaining[l]) remaining[l] = ROTATE_PAIRS;
		run_traffic(0);
		repeat (`MD_FILTER_STAGES + 1) @(posedge clk);
		#1;
		out_lanes.delete();
		record_lanes = 1'b1;
		out_ready = 1'b1;
		drain_outputs();
		record_lanes = 1'b0;
		check_value("pairs out after prefill", out_lanes.size(), N * ROTATE_PAIRS);
		for (int k = 1; k < 3 * N && k < out_lanes.size(); k++)
			check_value("lane rotation", out_lanes[k], (out_lanes[k-1] + 1) % N);

		// Random traffic under random back-pressure
		force_pass = 1'b0;
		dense = 1'b0;
		ready_random = 1'b1;
		foreach (remaining[l]) remaining[l] = READY_PAIRS;
		run_traffic(0);
		drain_outputs();
		ready_random = 1'b0;
		out_ready = 1'b1;

		for (int l = 0; l < N; l++)
			check_value("pairs left in lane queue", exp_q[l].size(), 0);
		$display("errors: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- sim.f
+incdir+design
design/particle_pkg.sv
design/filter_bank_pkg.sv
design/pair_distance_filter.sv
design/pair_fifo.sv
design/round_robin_arbiter.sv
design/filter_bank.sv
verification/filter_bank_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the filter bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f \
	--top-module filter_bank_tb -o filter_bank_sim

./obj_dir/filter_bank_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
